// File: conn_manager.f
+incdir+include
hdl/conn_table_pkg.sv
hdl/conn_ctrl_pkg.sv
hdl/way_store.sv
hdl/lookup_pipe.sv
hdl/ctrl_fsm.sv
hdl/conn_manager.sv
tests/conn_manager_tb.sv

// File: hdl/conn_ctrl_pkg.sv
package conn_ctrl_pkg;

    import conn_table_pkg::*;

    // ------------------------------------------------------------
    // control stream encodings
    // ------------------------------------------------------------

    typedef enum logic [0:0] {
        OP_DEACTIVATE = 1'b0,
        OP_ACTIVATE   = 1'b1
    } ctrl_op_e;

    // full only ever comes back for activate
    typedef enum logic [0:0] {
        ST_DONE = 1'b0,
        ST_FULL = 1'b1
    } ctrl_status_e;

    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_FETCH   = 2'd1,
        S_RESPOND = 2'd2
    } ctrl_state_e;

    typedef struct packed {
        ctrl_op_e op;
        key_t     key;
    } ctrl_req_t;

    // handle only meaningful for a done activate
    typedef struct packed {
        ctrl_status_e status;
        handle_t      handle;
    } ctrl_rsp_t;

endpackage

// File: hdl/conn_manager.sv
`timescale 1ns/1ps
`default_nettype none

module conn_manager
    import conn_table_pkg::*, conn_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // forward lookup, key in
    input  logic        lookup_req_valid,
    input  key_t        lookup_req_key,
    output logic        lookup_req_ready,

    // forward lookup, hit and handle out
    output logic        lookup_rsp_valid,
    output lookup_rsp_t lookup_rsp,
    input  logic        lookup_rsp_ready,

    // activate / deactivate requests
    input  logic        ctrl_req_valid,
    input  ctrl_req_t   ctrl_req,
    output logic        ctrl_req_ready,

    // control status
    output logic        ctrl_rsp_valid,
    output ctrl_rsp_t   ctrl_rsp,
    input  logic        ctrl_rsp_ready
);

    // ------------------------------------------------------------
    // way interconnect
    // ------------------------------------------------------------

    logic             lk_en;
    index_t           lk_index;
    key_t [WAY_N-1:0] lk_tag;
    logic [WAY_N-1:0] lk_valid;

    index_t           ct_index;
    key_t [WAY_N-1:0] ct_tag;
    logic [WAY_N-1:0] ct_valid;

    logic [WAY_N-1:0] wr_en;
    index_t           wr_index;
    key_t             wr_tag;
    logic             wr_valid;

    // one store per way, shared index and data, own write enable
    for (genvar w = 0; w < WAY_N; w++) begin : g_way
        way_store way_store_inst (
            .clk      (clk),
            .rst      (rst),
            .lk_en    (lk_en),
            .lk_index (lk_index),
            .lk_tag   (lk_tag[w]),
            .lk_valid (lk_valid[w]),
            .ct_index (ct_index),
            .ct_tag   (ct_tag[w]),
            .ct_valid (ct_valid[w]),
            .wr_en    (wr_en[w]),
            .wr_index (wr_index),
            .wr_tag   (wr_tag),
            .wr_valid (wr_valid)
        );
    end

    // ------------------------------------------------------------
    // lookup and control engines
    // ------------------------------------------------------------

    lookup_pipe lookup_pipe_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (lookup_req_valid),
        .req_key   (lookup_req_key),
        .req_ready (lookup_req_ready),
        .rsp_valid (lookup_rsp_valid),
        .rsp       (lookup_rsp),
        .rsp_ready (lookup_rsp_ready),
        .rd_en     (lk_en),
        .rd_index  (lk_index),
        .way_tag   (lk_tag),
        .way_valid (lk_valid)
    );

    ctrl_fsm ctrl_fsm_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (ctrl_req_valid),
        .req       (ctrl_req),
        .req_ready (ctrl_req_ready),
        .rsp_valid (ctrl_rsp_valid),
        .rsp       (ctrl_rsp),
        .rsp_ready (ctrl_rsp_ready),
        .rd_index  (ct_index),
        .way_tag   (ct_tag),
        .way_valid (ct_valid),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .wr_valid  (wr_valid)
    );

endmodule

`default_nettype wire

// File: hdl/conn_table_pkg.sv
package conn_table_pkg;

    // ------------------------------------------------------------
    // table geometry
    // ------------------------------------------------------------

    // connection key, stored whole as the tag
    localparam int KEY_W   = 32;
    // index bits per way
    localparam int HASH_W  = 8;
    localparam int WAY_N   = 4;
    localparam int WAY_W   = $clog2(WAY_N);
    localparam int INDEX_N = 1 << HASH_W;

    typedef logic [KEY_W-1:0]  key_t;
    typedef logic [HASH_W-1:0] index_t;
    typedef logic [WAY_W-1:0]  way_t;

    // handle names one slot: way on top, index below
    typedef struct packed {
        way_t   way;
        index_t index;
    } handle_t;

    // forward lookup result, handle is zero on a miss
    typedef struct packed {
        logic    hit;
        handle_t handle;
    } lookup_rsp_t;

    // xor all index-wide lanes of the key together
    function automatic index_t fold_hash(input key_t key);
        index_t acc;
        acc = '0;
        for (int i = 0; i < KEY_W / HASH_W; i++) begin
            acc = acc ^ key[i*HASH_W +: HASH_W];
        end
        return acc;
    endfunction

endpackage

// File: hdl/ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm
    import conn_table_pkg::*, conn_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // request stream
    input  logic                  req_valid,
    input  ctrl_req_t             req,
    output logic                  req_ready,

    // response stream
    output logic                  rsp_valid,
    output ctrl_rsp_t             rsp,
    input  logic                  rsp_ready,

    // control read of all ways
    output index_t                rd_index,
    input  key_t [WAY_N-1:0]      way_tag,
    input  logic [WAY_N-1:0]      way_valid,

    // write to the chosen way(s)
    output logic [WAY_N-1:0]      wr_en,
    output index_t                wr_index,
    output key_t                  wr_tag,
    output logic                  wr_valid
);

    ctrl_state_e      state;
    ctrl_req_t        req_q;
    index_t           hash_q;
    logic             rsp_valid_q;
    ctrl_rsp_t        rsp_q;
    logic [WAY_N-1:0] wr_mask_q;

    logic [WAY_N-1:0] hit_mask;
    logic [WAY_N-1:0] pick_mask;
    logic [WAY_N-1:0] mask_d;
    way_t             free_way;
    logic             full;
    ctrl_rsp_t        rsp_d;

    // ------------------------------------------------------------
    // read issue
    // ------------------------------------------------------------

    // only accept while idle
    assign req_ready = (state == S_IDLE);

    // address goes out with the accepted request, data lands in fetch
    assign rd_index = (state == S_IDLE) ? fold_hash(req.key) : hash_q;

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            req_q  <= req;
            hash_q <= fold_hash(req.key);
        end
    end

    // ------------------------------------------------------------
    // way choice, all ways checked at once
    // ------------------------------------------------------------

    always_comb begin
        full      = &way_valid;
        free_way  = '0;
        hit_mask  = '0;
        pick_mask = '0;
        // lowest free way
        for (int w = WAY_N - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                free_way = way_t'(w);
            end
        end
        for (int w = 0; w < WAY_N; w++) begin
            // deactivate hits every copy of the key
            hit_mask[w]  = way_valid[w] && (way_tag[w] == req_q.key);
            pick_mask[w] = !full && (way_t'(w) == free_way);
        end
    end

    always_comb begin
        if (req_q.op == OP_ACTIVATE) begin
            mask_d = pick_mask;
            if (full) begin
                rsp_d.status = ST_FULL;
                rsp_d.handle = '0;
            end else begin
                rsp_d.status       = ST_DONE;
                rsp_d.handle.way   = free_way;
                rsp_d.handle.index = hash_q;
            end
        end else begin
            mask_d       = hit_mask;
            rsp_d.status = ST_DONE;
            rsp_d.handle = '0;
        end
    end

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            rsp_valid_q <= 1'b0;
            wr_mask_q   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state       <= S_RESPOND;
                    rsp_valid_q <= 1'b1;
                    wr_mask_q   <= mask_d;
                end
                S_RESPOND: begin
                    // write lasts one cycle even if the response waits
                    wr_mask_q <= '0;
                    if (rsp_ready) begin
                        rsp_valid_q <= 1'b0;
                        state       <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp       = rsp_q;

    // write fields from the latched request
    assign wr_en    = wr_mask_q;
    assign wr_index = hash_q;
    assign wr_tag   = req_q.key;
    assign wr_valid = (req_q.op == OP_ACTIVATE);

    a_rsp_in_respond: assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid |-> (state == S_RESPOND)
    );

    // activate fills exactly one slot at most
    a_one_activate_write: assert property (
        @(posedge clk) disable iff (rst)
        wr_valid |-> $onehot0(wr_en)
    );

endmodule

`default_nettype wire

// File: hdl/lookup_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_pipe
    import conn_table_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // request stream
    input  logic                  req_valid,
    input  key_t                  req_key,
    output logic                  req_ready,

    // response stream
    output logic                  rsp_valid,
    output lookup_rsp_t           rsp,
    input  logic                  rsp_ready,

    // read side of all ways
    output logic                  rd_en,
    output index_t                rd_index,
    input  key_t [WAY_N-1:0]      way_tag,
    input  logic [WAY_N-1:0]      way_valid
);

    // ------------------------------------------------------------
    // pipeline control
    // ------------------------------------------------------------

    logic   advance;
    logic   s1_valid;
    key_t   s1_key;
    index_t s1_index;
    logic   hit_d;
    way_t   way_d;

    // move when the output slot is empty or being taken
    assign advance   = !rsp_valid || rsp_ready;
    assign req_ready = advance;

    // stage 1: hash straight off the request, ram registers it
    assign rd_index = fold_hash(req_key);
    // freeze the way read data along with the pipe
    assign rd_en    = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= req_valid;
            rsp_valid <= s1_valid;
        end
    end

    // key and index ride alongside the ram read
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_key   <= req_key;
            s1_index <= rd_index;
        end
    end

    // ------------------------------------------------------------
    // stage 2: tag compare
    // ------------------------------------------------------------

    // scan downward so the lowest matching way wins
    always_comb begin
        hit_d = 1'b0;
        way_d = '0;
        for (int w = WAY_N - 1; w >= 0; w--) begin
            if (way_valid[w] && (way_tag[w] == s1_key)) begin
                hit_d = 1'b1;
                way_d = way_t'(w);
            end
        end
    end

    // miss leaves a zero handle
    always_ff @(posedge clk) begin
        if (advance) begin
            rsp.hit          <= hit_d;
            rsp.handle.way   <= hit_d ? way_d : '0;
            rsp.handle.index <= hit_d ? s1_index : '0;
        end
    end

    // stalled response must not move
    a_rsp_stable: assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    );

endmodule

`default_nettype wire

// File: hdl/way_store.sv
`timescale 1ns/1ps
`default_nettype none

module way_store
    import conn_table_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // lookup read port, held when lk_en is low
    input  logic   lk_en,
    input  index_t lk_index,
    output key_t   lk_tag,
    output logic   lk_valid,

    // control read port, reads every cycle
    input  index_t ct_index,
    output key_t   ct_tag,
    output logic   ct_valid,

    // single write port
    input  logic   wr_en,
    input  index_t wr_index,
    input  key_t   wr_tag,
    input  logic   wr_valid
);

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    // tags in a plain ram
    key_t               tag_mem [INDEX_N];
    // valid bits in flops so reset empties the way
    logic [INDEX_N-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= wr_valid;
        end
    end

    // ------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------

    // registered, read-first: same-edge write shows up next read
    always_ff @(posedge clk) begin
        if (lk_en) begin
            lk_tag <= tag_mem[lk_index];
        end
        ct_tag <= tag_mem[ct_index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lk_valid <= 1'b0;
            ct_valid <= 1'b0;
        end else begin
            // lookup side freezes with the stalled pipe
            if (lk_en) begin
                lk_valid <= valid_q[lk_index];
            end
            ct_valid <= valid_q[ct_index];
        end
    end

    // a write with an X index would corrupt an unknown slot
    a_wr_index_known: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_index)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the connection table testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f conn_manager.f \
    --top-module conn_manager_tb \
    -o conn_manager_sim \
    && ./obj_dir/conn_manager_sim | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -qx "Done: no errors" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// File: include/conn_manager_tasks.svh
`ifndef CONN_MANAGER_TASKS_SVH
`define CONN_MANAGER_TASKS_SVH

// ------------------------------------------------------------
// reference model
// ------------------------------------------------------------

// one (valid, tag) slot per way and index
logic ref_valid [WAY_N][INDEX_N];
key_t ref_tag   [WAY_N][INDEX_N];

localparam key_t BASE_KEY = 32'h1234_5678;
localparam int   STREAM_N = 24;

// table starts empty after reset
task automatic clear_model();
    for (int w = 0; w < WAY_N; w++) begin
        for (int i = 0; i < INDEX_N; i++) begin
            ref_valid[w][i] = 1'b0;
            ref_tag[w][i]   = '0;
        end
    end
endtask

// index is the xor of the four key bytes
function automatic index_t key_index(input key_t key);
    return key[7:0] ^ key[15:8] ^ key[23:16] ^ key[31:24];
endfunction

// same byte in two lanes cancels out in the index
function automatic key_t collide(input int k);
    logic [7:0] b;
    b = k[7:0];
    return BASE_KEY ^ {16'h0000, b, b};
endfunction

// first matching way from way 0 upward
function automatic lookup_rsp_t model_lookup(input key_t key);
    lookup_rsp_t r;
    index_t      idx;
    idx = key_index(key);
    r   = '0;
    for (int w = 0; w < WAY_N; w++) begin
        if (!r.hit && ref_valid[w][idx] && ref_tag[w][idx] == key) begin
            r.hit          = 1'b1;
            r.handle.way   = way_t'(w);
            r.handle.index = idx;
        end
    end
    return r;
endfunction

// applies the request to the model and returns the expected response
function automatic ctrl_rsp_t model_ctrl(input ctrl_op_e op, input key_t key);
    ctrl_rsp_t r;
    index_t    idx;
    logic      placed;
    idx    = key_index(key);
    r      = '0;
    placed = 1'b0;
    if (op == OP_ACTIVATE) begin
        // full unless a free way turns up
        r.status = ST_FULL;
        for (int w = 0; w < WAY_N; w++) begin
            if (!placed && !ref_valid[w][idx]) begin
                ref_valid[w][idx] = 1'b1;
                ref_tag[w][idx]   = key;
                placed            = 1'b1;
                r.status          = ST_DONE;
                r.handle.way      = way_t'(w);
                r.handle.index    = idx;
            end
        end
    end else begin
        // every copy of the key goes away
        for (int w = 0; w < WAY_N; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == key) begin
                ref_valid[w][idx] = 1'b0;
            end
        end
    end
    return r;
endfunction

// ------------------------------------------------------------
// drive helpers enter and leave on a falling edge
// ------------------------------------------------------------

task automatic send_ctrl(input string name, input ctrl_op_e op, input key_t key);
    int   cnt;
    logic taken;
    cnt             = 0;
    taken           = 1'b0;
    ctrl_req_valid  = 1'b1;
    ctrl_req.op     = op;
    ctrl_req.key    = key;
    while (!taken && cnt < TIMEOUT) begin
        // sample settled ready ahead of the accepting edge
        #1;
        taken = ctrl_req_ready;
        @(negedge clk);
        cnt++;
    end
    ctrl_req_valid = 1'b0;
    assert (taken) else begin
        other_errors++;
        $display("%s: control request was never accepted", name);
    end
endtask

task automatic wait_ctrl_rsp(input string name, input ctrl_rsp_t exp);
    int cnt;
    cnt = 0;
    while (!ctrl_rsp_valid && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
    end
    assert (ctrl_rsp_valid) else begin
        other_errors++;
        $display("%s: no control response before the timeout", name);
    end
    if (ctrl_rsp_valid) begin
        assert (ctrl_rsp == exp) else begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, ctrl_rsp);
        end
    end
    // response taken on this edge
    @(negedge clk);
endtask

task automatic send_lookup(input string name, input key_t key);
    int   cnt;
    logic taken;
    cnt              = 0;
    taken            = 1'b0;
    lookup_req_valid = 1'b1;
    lookup_req_key   = key;
    while (!taken && cnt < TIMEOUT) begin
        #1;
        taken = lookup_req_ready;
        @(negedge clk);
        cnt++;
    end
    lookup_req_valid = 1'b0;
    assert (taken) else begin
        other_errors++;
        $display("%s: lookup request was never accepted", name);
    end
endtask

task automatic wait_lookup_rsp(input string name, input lookup_rsp_t exp);
    int cnt;
    cnt = 0;
    while (!lookup_rsp_valid && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
    end
    assert (lookup_rsp_valid) else begin
        other_errors++;
        $display("%s: no lookup response before the timeout", name);
    end
    if (lookup_rsp_valid) begin
        assert (lookup_rsp == exp) else begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, lookup_rsp);
        end
    end
    @(negedge clk);
endtask

task automatic check_lookup(input string name, input key_t key, input lookup_rsp_t exp);
    send_lookup(name, key);
    wait_lookup_rsp(name, exp);
endtask

// expected value straight from the model
task automatic run_ctrl(input string name, input ctrl_op_e op, input key_t key);
    ctrl_rsp_t exp;
    exp = model_ctrl(op, key);
    send_ctrl(name, op, key);
    wait_ctrl_rsp(name, exp);
endtask

// ------------------------------------------------------------
// directed tests
// ------------------------------------------------------------

task automatic reset_test();
    assert (lookup_req_ready && ctrl_req_ready) else begin
        mismatches++;
        $display("Mismatch reset: expected ready 11, actual %b%b",
                 lookup_req_ready, ctrl_req_ready);
    end
    check_lookup("reset", 32'h0000_0000, '0);
    check_lookup("reset", 32'hdead_beef, '0);
    check_lookup("reset", BASE_KEY, '0);
endtask

// four keys on one index land in ways 0..3
task automatic fill_ways_test();
    ctrl_rsp_t   want;
    lookup_rsp_t hit;
    for (int k = 0; k < WAY_N; k++) begin
        want.status       = ST_DONE;
        want.handle.way   = way_t'(k);
        want.handle.index = key_index(collide(k));
        void'(model_ctrl(OP_ACTIVATE, collide(k)));
        send_ctrl("fill_ways", OP_ACTIVATE, collide(k));
        wait_ctrl_rsp("fill_ways", want);
    end
    for (int k = 0; k < WAY_N; k++) begin
        hit.hit    = 1'b1;
        hit.handle = {way_t'(k), key_index(collide(k))};
        check_lookup("fill_ways", collide(k), hit);
    end
endtask

task automatic full_way_test();
    void'(model_ctrl(OP_ACTIVATE, collide(4)));
    send_ctrl("full_way", OP_ACTIVATE, collide(4));
    wait_ctrl_rsp("full_way", {ST_FULL, 10'h000});
    check_lookup("full_way", collide(4), '0);
endtask

// way 1 is freed and then reused by the next colliding key
task automatic deactivate_test();
    lookup_rsp_t hit;
    void'(model_ctrl(OP_DEACTIVATE, collide(1)));
    send_ctrl("deactivate", OP_DEACTIVATE, collide(1));
    wait_ctrl_rsp("deactivate", {ST_DONE, 10'h000});
    check_lookup("deactivate", collide(1), '0);
    for (int k = 0; k < WAY_N; k++) begin
        if (k != 1) begin
            hit.hit    = 1'b1;
            hit.handle = {way_t'(k), key_index(collide(k))};
            check_lookup("deactivate", collide(k), hit);
        end
    end
    void'(model_ctrl(OP_ACTIVATE, collide(5)));
    send_ctrl("deactivate", OP_ACTIVATE, collide(5));
    wait_ctrl_rsp("deactivate", {ST_DONE, way_t'(1), key_index(collide(5))});
endtask

task automatic stalled_stream_test();
    key_t        act [8];
    key_t        keys [STREAM_N];
    lookup_rsp_t exp_q [$];
    lookup_rsp_t held_rsp;
    lookup_rsp_t want;
    logic        held;
    logic [31:0] r;
    int          sent;
    int          got;
    int          cyc;
    for (int i = 0; i < 8; i++) begin
        act[i] = $random(seed);
        run_ctrl("stalled_stream", OP_ACTIVATE, act[i]);
    end
    // mix of active keys and fresh ones
    for (int i = 0; i < STREAM_N; i++) begin
        r = $random(seed);
        if (r[0]) begin
            keys[i] = act[r[3:1]];
        end else begin
            keys[i] = $random(seed);
        end
    end
    held = 1'b0;
    sent = 0;
    got  = 0;
    cyc  = 0;
    while (got < STREAM_N && cyc < STREAM_N * 8) begin
        @(negedge clk);
        cyc++;
        r = $random(seed);
        // fully stalled at first so both stages fill
        lookup_rsp_ready = (cyc > 8) && r[0];
        if (held) begin
            assert (lookup_rsp_valid) else begin
                other_errors++;
                $display("stalled_stream: stalled response was dropped");
            end
            assert (lookup_rsp == held_rsp) else begin
                mismatches++;
                $display("Mismatch stalled_stream: expected %h, actual %h",
                         held_rsp, lookup_rsp);
            end
        end
        held = 1'b0;
        if (lookup_rsp_valid && lookup_rsp_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("stalled_stream: response with no request outstanding");
            end else begin
                want = exp_q.pop_front();
                assert (lookup_rsp == want) else begin
                    mismatches++;
                    $display("Mismatch stalled_stream: expected %h, actual %h",
                             want, lookup_rsp);
                end
                got++;
            end
        end else if (lookup_rsp_valid) begin
            held     = 1'b1;
            held_rsp = lookup_rsp;
        end
        lookup_req_valid = (sent < STREAM_N);
        if (sent < STREAM_N) begin
            lookup_req_key = keys[sent];
        end
        #1;
        if (lookup_req_valid && lookup_req_ready) begin
            exp_q.push_back(model_lookup(keys[sent]));
            sent++;
        end
    end
    lookup_req_valid = 1'b0;
    lookup_rsp_ready = 1'b1;
    assert (got == STREAM_N) else begin
        other_errors++;
        $display("stalled_stream: only %0d of %0d responses before the timeout",
                 got, STREAM_N);
    end
    // nothing extra may trail the stream
    repeat (4) begin
        @(negedge clk);
        assert (!lookup_rsp_valid) else begin
            other_errors++;
            $display("stalled_stream: extra lookup response after the stream");
        end
    end
endtask

task automatic ctrl_backpressure_test();
    ctrl_rsp_t exp;
    ctrl_rsp_t first;
    int        cnt;
    exp            = model_ctrl(OP_ACTIVATE, 32'hcafe_0001);
    ctrl_rsp_ready = 1'b0;
    send_ctrl("ctrl_backpressure", OP_ACTIVATE, 32'hcafe_0001);
    cnt = 0;
    while (!ctrl_rsp_valid && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
    end
    first = ctrl_rsp;
    assert (ctrl_rsp_valid && first == exp) else begin
        mismatches++;
        $display("Mismatch ctrl_backpressure: expected %h, actual %h", exp, first);
    end
    repeat (5) begin
        @(negedge clk);
        assert (ctrl_rsp_valid && ctrl_rsp == first) else begin
            mismatches++;
            $display("Mismatch ctrl_backpressure: expected %h, actual %h", first, ctrl_rsp);
        end
        assert (!ctrl_req_ready) else begin
            other_errors++;
            $display("ctrl_backpressure: request ready while a response waits");
        end
    end
    ctrl_rsp_ready = 1'b1;
    @(negedge clk);
    assert (!ctrl_rsp_valid && ctrl_req_ready) else begin
        other_errors++;
        $display("ctrl_backpressure: control path did not return to idle");
    end
endtask

`endif

// File: tests/conn_manager_tb.sv
`timescale 1ns/1ps

module conn_manager_tb
    import conn_table_pkg::*, conn_ctrl_pkg::*;
;

    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst;

    // lookup streams
    logic        lookup_req_valid;
    key_t        lookup_req_key;
    logic        lookup_req_ready;
    logic        lookup_rsp_valid;
    lookup_rsp_t lookup_rsp;
    logic        lookup_rsp_ready;

    // control streams
    logic        ctrl_req_valid;
    ctrl_req_t   ctrl_req;
    logic        ctrl_req_ready;
    logic        ctrl_rsp_valid;
    ctrl_rsp_t   ctrl_rsp;
    logic        ctrl_rsp_ready;

    int          mismatches;
    int          other_errors;
    integer      seed;

    `include "conn_manager_tasks.svh"

    conn_manager conn_manager_inst (
        .clk              (clk),
        .rst              (rst),
        .lookup_req_valid (lookup_req_valid),
        .lookup_req_key   (lookup_req_key),
        .lookup_req_ready (lookup_req_ready),
        .lookup_rsp_valid (lookup_rsp_valid),
        .lookup_rsp       (lookup_rsp),
        .lookup_rsp_ready (lookup_rsp_ready),
        .ctrl_req_valid   (ctrl_req_valid),
        .ctrl_req         (ctrl_req),
        .ctrl_req_ready   (ctrl_req_ready),
        .ctrl_rsp_valid   (ctrl_rsp_valid),
        .ctrl_rsp         (ctrl_rsp),
        .ctrl_rsp_ready   (ctrl_rsp_ready)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        mismatches       = 0;
        other_errors     = 0;
        seed             = 37023;
        rst              = 1'b1;
        lookup_req_valid = 1'b0;
        lookup_req_key   = '0;
        lookup_rsp_ready = 1'b1;
        ctrl_req_valid   = 1'b0;
        ctrl_req         = '0;
        ctrl_rsp_ready   = 1'b1;
        clear_model();

        // reset over four rising edges, released on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        reset_test();
        fill_ways_test();
        full_way_test();
        deactivate_test();
        stalled_stream_test();
        ctrl_backpressure_test();

        $display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
